/* verilog/cpuPkg.sv */
package cpuPkg;

	typedef logic [15:0] word;
	typedef logic [3:0] regIndex;

	// Encodings follow the ISA opcode table
	typedef enum logic [3:0] {
		OP_ADD    = 4'h0,
		OP_SUB    = 4'h1,
		OP_RED    = 4'h2,
		OP_XOR    = 4'h3,
		OP_SLL    = 4'h4,
		OP_SRA    = 4'h5,
		OP_ROR    = 4'h6,
		OP_PADDSB = 4'h7,
		OP_LW     = 4'h8,
		OP_SW     = 4'h9,
		OP_LHB    = 4'ha,
		OP_LLB    = 4'hb,
		OP_B      = 4'hc,
		OP_BR     = 4'hd,
		OP_PCS    = 4'he,
		OP_HLT    = 4'hf
	} opcode;

	// Bit positions in the 3-bit flag vector
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// Branch conditions, instr[11:9] of B and BR
	localparam logic [2:0] COND_NE = 3'b000;
	localparam logic [2:0] COND_EQ = 3'b001;
	localparam logic [2:0] COND_GT = 3'b010;
	localparam logic [2:0] COND_LT = 3'b011;
	localparam logic [2:0] COND_GE = 3'b100;
	localparam logic [2:0] COND_LE = 3'b101;
	localparam logic [2:0] COND_OV = 3'b110;
	localparam logic [2:0] COND_UN = 3'b111;

endpackage

/* verilog/controlUnit.sv */
module controlUnit (
	input cpuPkg::word instr,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic aluImm,
	output logic branch,
	output logic branchReg,
	output logic pcSave,
	output logic halt
);

	import cpuPkg::*;

	opcode op;

	assign op = opcode'(instr[15:12]);

	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluImm = 1'b0;
		branch = 1'b0;
		branchReg = 1'b0;
		pcSave = 1'b0;
		halt = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_XOR, OP_PADDSB: begin
				regWrite = 1'b1;
			end

			// Shift amount comes from the instruction
			OP_SLL, OP_SRA, OP_ROR: begin
				regWrite = 1'b1;
				aluImm = 1'b1;
			end

			// Load needs no separate read strobe
			OP_LW: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
			end

			OP_SW: begin
				memWrite = 1'b1;
			end

			OP_LHB, OP_LLB: begin
				regWrite = 1'b1;
				aluImm = 1'b1;
			end

			OP_B: begin
				branch = 1'b1;
			end

			OP_BR: begin
				branchReg = 1'b1;
			end

			OP_PCS: begin
				regWrite = 1'b1;
				pcSave = 1'b1;
			end

			OP_HLT: begin
				halt = 1'b1;
			end

			// RED behaves as a no-op
			default: begin
			end
		endcase
	end

endmodule

/* verilog/alu.sv */
module alu (
	input cpuPkg::opcode op,
	input cpuPkg::word a,
	input cpuPkg::word b,
	input logic [3:0] imm,
	input logic [7:0] immByte,
	output cpuPkg::word result,
	output logic [2:0] newFlags,
	output logic [2:0] flagWriteMask
);

	import cpuPkg::*;

	localparam logic [2:0] MASK_ALL = 3'b111;
	localparam logic [2:0] MASK_Z = 3'(1 << FLAG_Z);

	logic [16:0] sum;
	logic [16:0] diff;
	logic [31:0] rotated;
	logic [4:0] nibbleSum [4];
	logic overflow;

	// Clamp a 17-bit signed result to the 16-bit range
	function automatic word sat16(input logic [16:0] s);
		if (s[16] != s[15]) begin
			return s[16] ? 16'h8000 : 16'h7fff;
		end
		return s[15:0];
	endfunction

	// Returns {saturated, nibble}
	function automatic logic [4:0] addNibble(input logic [3:0] x, input logic [3:0] y);
		logic [4:0] s;
		s = {x[3], x} + {y[3], y};
		if (s[4] != s[3]) begin
			return {1'b1, s[4] ? 4'h8 : 4'h7};
		end
		return {1'b0, s[3:0]};
	endfunction

	assign sum = {a[15], a} + {b[15], b};
	assign diff = {a[15], a} - {b[15], b};
	assign rotated = {a, a} >> imm;

	for (genvar i = 0; i < 4; i++) begin : gNibble
		assign nibbleSum[i] = addNibble(a[4*i +: 4], b[4*i +: 4]);
	end

	always_comb begin
		result = '0;
		overflow = 1'b0;
		flagWriteMask = '0;
		case (op)
			OP_ADD: begin
				result = sat16(sum);
				overflow = sum[16] ^ sum[15];
				flagWriteMask = MASK_ALL;
			end
			OP_SUB: begin
				result = sat16(diff);
				overflow = diff[16] ^ diff[15];
				flagWriteMask = MASK_ALL;
			end
			OP_PADDSB: begin
				result = {nibbleSum[3][3:0], nibbleSum[2][3:0], nibbleSum[1][3:0],
					nibbleSum[0][3:0]};
				overflow = nibbleSum[3][4] | nibbleSum[2][4] | nibbleSum[1][4] | nibbleSum[0][4];
				flagWriteMask = MASK_ALL;
			end
			OP_XOR: begin
				result = a ^ b;
				flagWriteMask = MASK_Z;
			end
			OP_SLL: begin
				result = a << imm;
				flagWriteMask = MASK_Z;
			end
			OP_SRA: begin
				result = word'($signed(a) >>> imm);
				flagWriteMask = MASK_Z;
			end
			OP_ROR: begin
				result = rotated[15:0];
				flagWriteMask = MASK_Z;
			end
			OP_LLB: result = {a[15:8], immByte};
			OP_LHB: result = {immByte, a[7:0]};
			// Byte offset is the word offset doubled
			OP_LW, OP_SW: result = a + {{11{imm[3]}}, imm, 1'b0};
			default: result = '0;
		endcase
	end

	always_comb begin
		newFlags = '0;
		newFlags[FLAG_Z] = (result == '0);
		newFlags[FLAG_V] = overflow;
		newFlags[FLAG_N] = result[15];
	end

endmodule

/* verilog/registerFile.sv */
module registerFile (
	input logic clk,
	input logic rst,
	input cpuPkg::regIndex readA,
	input cpuPkg::regIndex readB,
	input logic writeEn,
	input cpuPkg::regIndex writeAddr,
	input cpuPkg::word writeData,
	output cpuPkg::word dataA,
	output cpuPkg::word dataB
);

	import cpuPkg::*;

	word regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// R0 is hardwired to zero
	assign dataA = (readA == '0) ? '0 : regs[readA];
	assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

/* verilog/dataMemory.sv */
module dataMemory #(
	parameter int DATA_ADDR_BITS = 8
) (
	input logic clk,
	input logic writeEn,
	input cpuPkg::word addr,
	input cpuPkg::word writeData,
	output cpuPkg::word readData
);

	import cpuPkg::*;

	word mem [2**DATA_ADDR_BITS];

	initial begin
		for (int i = 0; i < 2**DATA_ADDR_BITS; i++) begin
			mem[i] = '0;
		end
	end

	// Word index drops the byte bit
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[addr[DATA_ADDR_BITS:1]] <= writeData;
		end
	end

	assign readData = mem[addr[DATA_ADDR_BITS:1]];

	assert property (@(posedge clk) writeEn |-> !addr[0])
		else $error("dataMemory: odd store address %h", addr);

endmodule

/* verilog/branchUnit.sv */
module branchUnit (
	input logic clk,
	input logic rst,
	input logic branch,
	input logic branchReg,
	input logic halt,
	input logic [2:0] cond,
	input logic [8:0] offset,
	input cpuPkg::word target,
	input logic [2:0] newFlags,
	input logic [2:0] flagWriteMask,
	output cpuPkg::word pc,
	output cpuPkg::word pcNext,
	output logic halted
);

	import cpuPkg::*;

	logic [2:0] flags;
	logic condTrue;
	logic taken;
	word branchTarget;
	word nextPc;

	always_comb begin
		case (cond)
			COND_NE: condTrue = !flags[FLAG_Z];
			COND_EQ: condTrue = flags[FLAG_Z];
			COND_GT: condTrue = !flags[FLAG_Z] && !flags[FLAG_N];
			COND_LT: condTrue = flags[FLAG_N];
			COND_GE: condTrue = flags[FLAG_Z] || !flags[FLAG_N];
			COND_LE: condTrue = flags[FLAG_Z] || flags[FLAG_N];
			COND_OV: condTrue = flags[FLAG_V];
			default: condTrue = 1'b1;
		endcase
	end

	assign pcNext = pc + 16'd2;
	assign taken = (branch || branchReg) && condTrue;
	assign branchTarget = branchReg ? target : pcNext + {{6{offset[8]}}, offset, 1'b0};
	assign nextPc = taken ? branchTarget : pcNext;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			flags <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			// Only the flags named by the mask change
			flags <= (flags & ~flagWriteMask) | (newFlags & flagWriteMask);
			if (halt) begin
				halted <= 1'b1;
			end else begin
				pc <= nextPc;
			end
		end
	end

	// A register target for BR can carry an odd address
	assert property (@(posedge clk) disable iff (rst) !pc[0])
		else $error("branchUnit: pc is not word aligned: %h", pc);

endmodule

/* verilog/cpu.sv */
module cpu #(
	parameter int DATA_ADDR_BITS = 8
) (
	input logic clk,
	input logic rst,
	input cpuPkg::word instr,
	output cpuPkg::word pc,
	output logic commitValid,
	output cpuPkg::regIndex commitReg,
	output cpuPkg::word commitData,
	output logic storeValid,
	output cpuPkg::word storeAddr,
	output cpuPkg::word storeData,
	output logic halted
);

	import cpuPkg::*;

	opcode op;
	logic regWrite, memWrite, memToReg, aluImm;
	logic branch, branchReg, pcSave, halt;
	regIndex readA, readB;
	word rsData, rtData, aluB;
	word aluResult, memData, pcNext, wbData;
	logic [2:0] newFlags, flagWriteMask;

	assign op = opcode'(instr[15:12]);

	controlUnit i_controlUnit (
		.instr(instr),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.aluImm(aluImm),
		.branch(branch),
		.branchReg(branchReg),
		.pcSave(pcSave),
		.halt(halt)
	);

	// Byte loads modify rd in place and stores read their data from rt
	assign readA = (op == OP_LHB || op == OP_LLB) ? instr[11:8] : instr[7:4];
	assign readB = memWrite ? instr[11:8] : instr[3:0];

	registerFile i_registerFile (
		.clk(clk),
		.rst(rst),
		.readA(readA),
		.readB(readB),
		.writeEn(commitValid),
		.writeAddr(instr[11:8]),
		.writeData(wbData),
		.dataA(rsData),
		.dataB(rtData)
	);

	assign aluB = aluImm ? {8'h00, instr[7:0]} : rtData;

	alu i_alu (
		.op(op),
		.a(rsData),
		.b(aluB),
		.imm(instr[3:0]),
		.immByte(instr[7:0]),
		.result(aluResult),
		.newFlags(newFlags),
		.flagWriteMask(flagWriteMask)
	);

	// Keep the RAM untouched while reset is held
	dataMemory #(
		.DATA_ADDR_BITS(DATA_ADDR_BITS)
	) i_dataMemory (
		.clk(clk),
		.writeEn(storeValid && !rst),
		.addr(aluResult),
		.writeData(rtData),
		.readData(memData)
	);

	branchUnit i_branchUnit (
		.clk(clk),
		.rst(rst),
		.branch(branch),
		.branchReg(branchReg),
		.halt(halt),
		.cond(instr[11:9]),
		.offset(instr[8:0]),
		.target(rsData),
		.newFlags(newFlags),
		.flagWriteMask(flagWriteMask),
		.pc(pc),
		.pcNext(pcNext),
		.halted(halted)
	);

	assign wbData = memToReg ? memData : (pcSave ? pcNext : aluResult);

	assign commitValid = regWrite && !halted;
	assign commitReg = instr[11:8];
	assign commitData = wbData;
	assign storeValid = memWrite && !halted;
	assign storeAddr = aluResult;
	assign storeData = rtData;

endmodule

/* tb/traceChecker.sv */
module traceChecker #(
	parameter int ADDR_BITS = 9,
	parameter int TRACE_BASE = 256
) (
	input logic clk,
	input logic rst,
	input logic [15:0] stim [1 << ADDR_BITS],
	input logic commitValid,
	input logic [3:0] commitReg,
	input logic [15:0] commitData,
	input logic storeValid,
	input logic [15:0] storeAddr,
	input logic [15:0] storeData,
	input logic halted,
	output int passCount,
	output int failCount,
	output logic traceDone
);

	// Event kinds in the first column of the trace
	localparam logic [15:0] KIND_END = 16'h0000;
	localparam logic [15:0] KIND_REG = 16'h0001;
	localparam logic [15:0] KIND_STORE = 16'h0002;
	localparam logic [15:0] KIND_HALT = 16'h0003;
	localparam logic [15:0] KIND_GROUP = 16'h000e;

	int passes = 0;
	int fails = 0;
	int entry = 0;
	int groupErrors = 0;
	logic done = 1'b0;
	logic haltSeen = 1'b0;

	assign passCount = passes;
	assign failCount = fails;
	assign traceDone = done;

	function automatic logic [15:0] field(input int e, input int f);
		return stim[ADDR_BITS'(TRACE_BASE + 3 * e + f)];
	endfunction

	function automatic string kindName(input logic [15:0] kind);
		case (kind)
			KIND_REG: return "register commit";
			KIND_STORE: return "store";
			KIND_HALT: return "halt";
			default: return "end of trace";
		endcase
	endfunction

	// Report finished groups and spot the end marker
	task automatic closeGroups();
		while (field(entry, 0) == KIND_GROUP) begin
			if (groupErrors == 0) begin
				$display("test %0d passed", field(entry, 1));
			end else begin
				$display("test %0d failed with %0d errors", field(entry, 1), groupErrors);
			end
			groupErrors = 0;
			entry++;
		end
		if (field(entry, 0) == KIND_END) begin
			done = 1'b1;
		end
	endtask

	task automatic compareEvent(input logic [15:0] kind, input logic [15:0] key,
		input logic [15:0] value, input string keyName, input string valueName);
		logic ok;
		ok = 1'b1;
		if (done) begin
			$display("The core produced a %s event after the trace had ended", kindName(kind));
			fails++;
			return;
		end
		if (field(entry, 0) != kind) begin
			$display("Trace entry %0d expects a %s event but the core produced a %s event",
				entry, kindName(field(entry, 0)), kindName(kind));
			ok = 1'b0;
		end else begin
			if (field(entry, 1) != key) begin
				$display("Error %s: expected %h, got %h", keyName, field(entry, 1), key);
				ok = 1'b0;
			end
			if (field(entry, 2) != value) begin
				$display("Error %s: expected %h, got %h", valueName, field(entry, 2), value);
				ok = 1'b0;
			end
		end
		if (ok) begin
			passes++;
		end else begin
			fails++;
			groupErrors++;
		end
		entry++;
		closeGroups();
	endtask

	// Sample mid-cycle since the commit ports settle one unit after the edge
	always @(negedge clk) begin
		if (!rst) begin
			if (halted && (commitValid || storeValid)) begin
				$display("The core wrote a register or memory while halted");
				fails++;
			end
			if (commitValid) begin
				compareEvent(KIND_REG, {12'h000, commitReg}, commitData, "commitReg",
					"commitData");
			end
			if (storeValid) begin
				compareEvent(KIND_STORE, storeAddr, storeData, "storeAddr", "storeData");
			end
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				compareEvent(KIND_HALT, 16'h0000, 16'h0000, "halted", "halted");
			end
		end
	end

endmodule

/* tb/cpuTb.sv */
module cpuTb;

	import cpuPkg::*;

	localparam int ADDR_BITS = 9;
	localparam int STIM_WORDS = 1 << ADDR_BITS;
	localparam int TRACE_BASE = 256;
	localparam int HALT_TIMEOUT = 2000;

	logic clk;
	logic rst;
	word instr;
	word pc;
	logic commitValid;
	regIndex commitReg;
	word commitData;
	logic storeValid;
	word storeAddr;
	word storeData;
	logic halted;
	logic [15:0] stim [STIM_WORDS];
	int passCount;
	int failCount;
	logic traceDone;
	logic failed;
	int cycles;

	cpu #(
		.DATA_ADDR_BITS(8)
	) i_cpu (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.pc(pc),
		.commitValid(commitValid),
		.commitReg(commitReg),
		.commitData(commitData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted)
	);

	traceChecker #(
		.ADDR_BITS(ADDR_BITS),
		.TRACE_BASE(TRACE_BASE)
	) i_traceChecker (
		.clk(clk),
		.rst(rst),
		.stim(stim),
		.commitValid(commitValid),
		.commitReg(commitReg),
		.commitData(commitData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.halted(halted),
		.passCount(passCount),
		.failCount(failCount),
		.traceDone(traceDone)
	);

	always #50 clk = ~clk;

	// Program space is the low 256 words and anything past it reads as HLT
	function automatic word fetch(input word addr);
		if (addr[15:9] != '0) begin
			return 16'hf000;
		end
		return stim[{1'b0, addr[8:1]}];
	endfunction

	always @(posedge clk) begin
		#1;
		instr = fetch(pc);
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		failed = 1'b0;
		cycles = 0;
		$readmemh("tb/programStimulus.hex", stim);
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("halted never rose within %0d cycles", HALT_TIMEOUT);
			$display("=== FAIL ===");
		end else begin
			// A few idle cycles to catch stray writes after HLT
			repeat (4) @(posedge clk);
			if (!traceDone) begin
				$display("The core halted before the expected trace was complete");
				failed = 1'b1;
			end
			$display("checks passed: %0d, failed: %0d", passCount, failCount);
			if (failed || failCount != 0) begin
				$display("=== FAIL ===");
			end else begin
				$display("=== PASS ===");
			end
		end
		$finish;
	end

endmodule

/* tb/programStimulus.hex */
// Words 000-0ff: program, indexed by pc / 2, eight words per line
// Words 100 on: expected trace as kind key value (1 commit, 2 store, 3 halt, e test end, 0 end)
@000
// pc 00: LLB/LHB constants, ADD and SUB saturation, XOR
B134 A112 B2FF A27F 0312 B400 A480 1541
// pc 10: shifts and PADDSB from pc 16
0611 1712 3812 4914 5A43 6B14 5C1F 7D12
// pc 20: stores and loads from pc 22
7E88 9102 BF20 98FF 93F3 8502 86FF 87F4
// pc 30: branches, the B9xx words in skipped slots must not commit
CC01 B9EE C201 B911 3A11 C202 B9AA B9BB
C601 CC01 B9CC BC4E D0C0 DEC0 B9DD EB00
// pc 50: LT and OV branches, PCS, HLT at pc 5a, then words that must never run
1D01 C601 B955 CC01 EE00 F000 B199 9100
@100
// Test 1
0001 0001 0034  0001 0001 1234
0001 0002 00ff  0001 0002 7fff
0001 0003 7fff  0001 0004 0000
0001 0004 8000  0001 0005 8000
0001 0006 2468  0001 0007 9235
0001 0008 6dcb  000e 0001 0000
// Test 2
0001 0009 2340  0001 000a f000
0001 000b 4123  0001 000c 0000
0001 000d 7123  0001 000e 7a88
000e 0002 0000
// Test 3
0002 0004 1234  0001 000f 0020
0002 001e 6dcb  0002 0026 7fff
0001 0005 1234  0001 0006 6dcb
0001 0007 0000  000e 0003 0000
// Test 4
0001 0009 2311  0001 000a 0000
0001 000c 004e  0001 000b 0050
0001 000d edcc  0001 000e 005a
000e 0004 0000
// Test 5
0003 0000 0000  000e 0005 0000
0000 0000 0000

/* files.f */
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/dataMemory.sv
verilog/branchUnit.sv
verilog/cpu.sv
tb/traceChecker.sv
tb/cpuTb.sv

/* Makefile */
OBJ = obj_dir

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module cpuTb -Mdir $(OBJ) -o simv

run: compile
	./$(OBJ)/simv | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all compile run clean
